// File: src/sat_types_pkg.sv
// problem data types: literal codes, variable index, decision level, variable record

package sat_types_pkg;

    // widest problem the 4-bit index and level fields can describe
    localparam int MAX_VARS = 15;

    // literal code of one variable inside a clause
    // 2'b00 and 2'b11 both mean the variable does not appear
    typedef logic [1:0] lit_t;

    localparam lit_t LIT_POS = 2'b01;
    localparam lit_t LIT_NEG = 2'b10;

    // variable number within the problem
    typedef logic [3:0] var_idx_t;

    // decision level, level 0 holds implications made before any decision
    typedef logic [3:0] lvl_t;

    // one record per variable
    typedef struct packed {
        logic assigned;
        logic value;
        // value came from a decision, so the variable owns its level
        logic decided;
        // that decision has already been inverted once
        logic flipped;
        lvl_t level;
    } var_state_t;

endpackage

// File: src/sat_ctrl_pkg.sv
// search control types: FSM state enum and evaluation status struct

package sat_ctrl_pkg;

    // controller states
    // IMPLY, DECIDE and BACKTRACK are the cycles right after the op is
    // committed, while the registered status catches up with the new record
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        EVAL      = 3'd1,
        IMPLY     = 3'd2,
        DECIDE    = 3'd3,
        BACKTRACK = 3'd4,
        FINISH    = 3'd5
    } search_state_t;

    // summary of the last clause evaluation
    typedef struct packed {
        logic                    all_sat;
        logic                    conflict;
        logic                    unit_valid;
        sat_types_pkg::var_idx_t unit_var;
        // value that makes the unit literal true
        logic                    unit_val;
        // every variable carries a value
        logic                    none_free;
    } eval_status_t;

endpackage

// File: src/sat_clause_regs.sv
// clause storage with per-clause enable, loaded by the host while the engine is idle

`timescale 1ns/1ps

module sat_clause_regs #(
    parameter int NUM_VARS    = 8,
    parameter int NUM_CLAUSES = 8
) (
    input  logic                                              clk,
    input  logic                                              rst_i,
    input  logic                                              wr_clause_i,
    input  logic [$clog2(NUM_CLAUSES)-1:0]                    wr_idx_i,
    input  sat_types_pkg::lit_t [NUM_VARS-1:0]                wr_clause_data_i,
    input  logic                                              clr_clauses_i,
    input  logic                                              busy_i,
    output sat_types_pkg::lit_t [NUM_CLAUSES-1:0][NUM_VARS-1:0] clauses_o,
    output logic [NUM_CLAUSES-1:0]                            clause_en_o
);

    import sat_types_pkg::*;

    lit_t [NUM_CLAUSES-1:0][NUM_VARS-1:0] clauses_q;
    logic [NUM_CLAUSES-1:0]               en_q;
    logic                                 wr_ok;
    logic                                 clr_ok;

    // host access only between runs
    assign wr_ok  = wr_clause_i && !busy_i;
    assign clr_ok = clr_clauses_i && !busy_i;

    // clause payload
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            clauses_q[wr_idx_i] <= wr_clause_data_i;
        end
    end

    // enables, a write in the same cycle as a clear survives it
    always_ff @(posedge clk) begin
        if (rst_i) begin
            en_q <= '0;
        end else begin
            if (clr_ok) begin
                en_q <= '0;
            end
            if (wr_ok) begin
                en_q[wr_idx_i] <= 1'b1;
            end
        end
    end

    assign clauses_o   = clauses_q;
    assign clause_en_o = en_q;

    // host must stay inside the clause table
    a_wr_idx_range: assert property (
        @(posedge clk) disable iff (rst_i)
        wr_clause_i |-> (int'(wr_idx_i) < NUM_CLAUSES)
    ) else $error("clause write index %0d out of range", wr_idx_i);

endmodule

// File: src/clause_eval.sv
// parallel clause evaluation: all-satisfied, conflict, first unit implication, registered

`timescale 1ns/1ps

module clause_eval #(
    parameter int NUM_VARS    = 8,
    parameter int NUM_CLAUSES = 8
) (
    input  logic                                              clk,
    input  logic                                              rst_i,
    input  sat_types_pkg::lit_t [NUM_CLAUSES-1:0][NUM_VARS-1:0] clauses_i,
    input  logic [NUM_CLAUSES-1:0]                            clause_en_i,
    input  sat_types_pkg::var_state_t [NUM_VARS-1:0]          var_states_i,
    output sat_ctrl_pkg::eval_status_t                        status_o
);

    import sat_types_pkg::*;
    import sat_ctrl_pkg::*;

    eval_status_t status_d;
    eval_status_t status_q;

    always_comb begin
        logic     c_sat;
        int       free_cnt;
        var_idx_t free_var;
        logic     free_val;
        lit_t     lit;
        logic     has_lit;

        status_d           = '0;
        status_d.all_sat   = 1'b1;
        status_d.none_free = 1'b1;

        for (int k = 0; k < NUM_VARS; k++) begin
            if (!var_states_i[k].assigned) begin
                status_d.none_free = 1'b0;
            end
        end

        // walk downwards so the lowest unit clause is the one that sticks
        for (int i = NUM_CLAUSES - 1; i >= 0; i--) begin
            c_sat    = 1'b0;
            free_cnt = 0;
            free_var = '0;
            free_val = 1'b0;
            for (int j = 0; j < NUM_VARS; j++) begin
                lit     = clauses_i[i][j];
                has_lit = (lit == LIT_POS) || (lit == LIT_NEG);
                if (has_lit && var_states_i[j].assigned) begin
                    if (var_states_i[j].value == (lit == LIT_POS)) begin
                        c_sat = 1'b1;
                    end
                end else if (has_lit) begin
                    free_cnt = free_cnt + 1;
                    free_var = var_idx_t'(j);
                    free_val = (lit == LIT_POS);
                end
            end

            if (clause_en_i[i] && !c_sat) begin
                status_d.all_sat = 1'b0;
                // an empty clause lands here too and counts as a conflict
                if (free_cnt == 0) begin
                    status_d.conflict = 1'b1;
                end else if (free_cnt == 1) begin
                    status_d.unit_valid = 1'b1;
                    status_d.unit_var   = free_var;
                    status_d.unit_val   = free_val;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            status_q <= '0;
        end else begin
            status_q <= status_d;
        end
    end

    assign status_o = status_q;

    // var_state_list indexes its records with unit_var
    a_unit_var_range: assert property (
        @(posedge clk) disable iff (rst_i)
        status_o.unit_valid |-> (int'(status_o.unit_var) < NUM_VARS)
    ) else $error("unit implication on variable %0d", status_o.unit_var);

endmodule

// File: src/var_state_list.sv
// per-variable records and decision level with decide, imply and backtrack

`timescale 1ns/1ps

module var_state_list #(
    parameter int NUM_VARS = 8
) (
    input  logic                                     clk,
    input  logic                                     rst_i,
    input  logic                                     clear_vars_i,
    input  logic                                     do_imply_i,
    input  logic                                     do_decide_i,
    input  logic                                     do_backtrack_i,
    input  sat_ctrl_pkg::eval_status_t               status_i,
    output sat_types_pkg::var_state_t [NUM_VARS-1:0] var_states_o,
    output sat_types_pkg::lvl_t                      cur_lvl_o,
    output logic                                     bt_none_o
);

    import sat_types_pkg::*;

    var_state_t [NUM_VARS-1:0] vars_q;
    lvl_t                      cur_lvl_q;
    lvl_t                      next_lvl;
    var_idx_t                  dec_idx;
    var_idx_t                  bt_idx;
    lvl_t                      bt_lvl;

    assign next_lvl = cur_lvl_q + 1'b1;

    // lowest unassigned variable
    always_comb begin
        dec_idx = '0;
        for (int k = NUM_VARS - 1; k >= 0; k--) begin
            if (!vars_q[k].assigned) begin
                dec_idx = var_idx_t'(k);
            end
        end
    end

    // newest decision not yet inverted, i.e. the highest such level
    always_comb begin
        bt_none_o = 1'b1;
        bt_idx    = '0;
        bt_lvl    = '0;
        for (int k = 0; k < NUM_VARS; k++) begin
            if (vars_q[k].assigned && vars_q[k].decided && !vars_q[k].flipped &&
                (bt_none_o || vars_q[k].level > bt_lvl)) begin
                bt_none_o = 1'b0;
                bt_idx    = var_idx_t'(k);
                bt_lvl    = vars_q[k].level;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || clear_vars_i) begin
            vars_q    <= '0;
            cur_lvl_q <= '0;
        end else if (do_backtrack_i) begin
            for (int k = 0; k < NUM_VARS; k++) begin
                if (var_idx_t'(k) == bt_idx) begin
                    // decision keeps its level, now with the other value
                    vars_q[k].value   <= ~vars_q[k].value;
                    vars_q[k].flipped <= 1'b1;
                end else if (vars_q[k].level >= bt_lvl) begin
                    vars_q[k] <= '0;
                end
            end
            cur_lvl_q <= bt_lvl;
        end else if (do_decide_i) begin
            vars_q[dec_idx] <= '{
                assigned: 1'b1,
                value:    1'b0,
                decided:  1'b1,
                flipped:  1'b0,
                level:    next_lvl
            };
            cur_lvl_q <= next_lvl;
        end else if (do_imply_i) begin
            vars_q[status_i.unit_var] <= '{
                assigned: 1'b1,
                value:    status_i.unit_val,
                decided:  1'b0,
                flipped:  1'b0,
                level:    cur_lvl_q
            };
        end
    end

    assign var_states_o = vars_q;
    assign cur_lvl_o    = cur_lvl_q;

    // controller must finish with unsat instead of backtracking into nothing
    a_bt_has_target: assert property (
        @(posedge clk) disable iff (rst_i)
        do_backtrack_i |-> !bt_none_o
    ) else $error("backtrack requested with no open decision");

endmodule

// File: src/sat_ctrl_core.sv
// DPLL control FSM: evaluate, imply, decide, backtrack, finish

`timescale 1ns/1ps

module sat_ctrl_core #(
    parameter int NUM_VARS    = 8,
    parameter int NUM_CLAUSES = 8
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  sat_ctrl_pkg::eval_status_t status_i,
    input  logic                       bt_none_i,
    output logic                       clear_vars_o,
    output logic                       do_imply_o,
    output logic                       do_decide_o,
    output logic                       do_backtrack_o,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       sat_o,
    output logic                       unsat_o
);

    import sat_types_pkg::*;
    import sat_ctrl_pkg::*;

    // index and level fields are 4 bits, clause index needs at least one bit
    if (NUM_VARS < 1 || NUM_VARS > MAX_VARS || NUM_CLAUSES < 2) begin : g_bad_size
        $error("unsupported problem size: %0d vars, %0d clauses", NUM_VARS, NUM_CLAUSES);
    end

    search_state_t state_q;
    search_state_t state_d;
    logic          accept;
    logic          first_q;
    logic          fin_sat;
    logic          fin_unsat;
    logic          sat_q;
    logic          unsat_q;

    assign accept = start_i && (state_q == IDLE || state_q == FINISH);

    always_comb begin
        state_d        = state_q;
        do_imply_o     = 1'b0;
        do_decide_o    = 1'b0;
        do_backtrack_o = 1'b0;
        fin_sat        = 1'b0;
        fin_unsat      = 1'b0;
        case (state_q)
            IDLE, FINISH: state_d = accept ? EVAL : IDLE;
            EVAL: begin
                // status right after a clear still shows the old records
                if (!first_q) begin
                    if (status_i.all_sat) begin
                        fin_sat = 1'b1;
                        state_d = FINISH;
                    end else if (status_i.conflict || status_i.none_free) begin
                        if (bt_none_i) begin
                            fin_unsat = 1'b1;
                            state_d   = FINISH;
                        end else begin
                            do_backtrack_o = 1'b1;
                            state_d        = BACKTRACK;
                        end
                    end else if (status_i.unit_valid) begin
                        do_imply_o = 1'b1;
                        state_d    = IMPLY;
                    end else begin
                        do_decide_o = 1'b1;
                        state_d     = DECIDE;
                    end
                end
            end
            IMPLY, DECIDE, BACKTRACK: state_d = EVAL;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            first_q <= 1'b0;
            sat_q   <= 1'b0;
            unsat_q <= 1'b0;
        end else begin
            state_q <= state_d;
            first_q <= accept;
            if (accept) begin
                sat_q   <= 1'b0;
                unsat_q <= 1'b0;
            end else begin
                sat_q   <= sat_q | fin_sat;
                unsat_q <= unsat_q | fin_unsat;
            end
        end
    end

    assign clear_vars_o = accept;
    assign busy_o       = (state_q != IDLE) && (state_q != FINISH);
    assign done_o       = (state_q == FINISH);
    assign sat_o        = sat_q;
    assign unsat_o      = unsat_q;

    a_one_verdict: assert property (
        @(posedge clk) disable iff (rst_i)
        !(sat_o && unsat_o)
    ) else $error("sat and unsat reported together");

endmodule

// File: src/sat_engine.sv
// top level of the SAT engine: clause store, clause evaluator, variable list, control FSM

`timescale 1ns/1ps

module sat_engine #(
    parameter int NUM_VARS    = 8,
    parameter int NUM_CLAUSES = 8
) (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               wr_clause_i,
    input  logic [$clog2(NUM_CLAUSES)-1:0]     wr_idx_i,
    input  sat_types_pkg::lit_t [NUM_VARS-1:0] wr_clause_data_i,
    input  logic                               clr_clauses_i,
    input  logic                               start_i,
    output logic                               busy_o,
    output logic                               done_o,
    output logic                               sat_o,
    output logic                               unsat_o,
    output logic [NUM_VARS-1:0]                assign_o,
    output sat_types_pkg::lvl_t                cur_lvl_o
);

    import sat_types_pkg::*;
    import sat_ctrl_pkg::*;

    lit_t [NUM_CLAUSES-1:0][NUM_VARS-1:0] clauses;
    logic [NUM_CLAUSES-1:0]               clause_en;
    var_state_t [NUM_VARS-1:0]            var_states;
    eval_status_t                         status;
    logic                                 clear_vars;
    logic                                 do_imply;
    logic                                 do_decide;
    logic                                 do_backtrack;
    logic                                 bt_none;
    logic                                 busy;

    sat_clause_regs #(
        .NUM_VARS    (NUM_VARS),
        .NUM_CLAUSES (NUM_CLAUSES)
    ) u_sat_clause_regs (
        .clk              (clk),
        .rst_i            (rst_i),
        .wr_clause_i      (wr_clause_i),
        .wr_idx_i         (wr_idx_i),
        .wr_clause_data_i (wr_clause_data_i),
        .clr_clauses_i    (clr_clauses_i),
        .busy_i           (busy),
        .clauses_o        (clauses),
        .clause_en_o      (clause_en)
    );

    clause_eval #(
        .NUM_VARS    (NUM_VARS),
        .NUM_CLAUSES (NUM_CLAUSES)
    ) u_clause_eval (
        .clk          (clk),
        .rst_i        (rst_i),
        .clauses_i    (clauses),
        .clause_en_i  (clause_en),
        .var_states_i (var_states),
        .status_o     (status)
    );

    var_state_list #(
        .NUM_VARS (NUM_VARS)
    ) u_var_state_list (
        .clk            (clk),
        .rst_i          (rst_i),
        .clear_vars_i   (clear_vars),
        .do_imply_i     (do_imply),
        .do_decide_i    (do_decide),
        .do_backtrack_i (do_backtrack),
        .status_i       (status),
        .var_states_o   (var_states),
        .cur_lvl_o      (cur_lvl_o),
        .bt_none_o      (bt_none)
    );

    sat_ctrl_core #(
        .NUM_VARS    (NUM_VARS),
        .NUM_CLAUSES (NUM_CLAUSES)
    ) u_sat_ctrl_core (
        .clk            (clk),
        .rst_i          (rst_i),
        .start_i        (start_i),
        .status_i       (status),
        .bt_none_i      (bt_none),
        .clear_vars_o   (clear_vars),
        .do_imply_o     (do_imply),
        .do_decide_o    (do_decide),
        .do_backtrack_o (do_backtrack),
        .busy_o         (busy),
        .done_o         (done_o),
        .sat_o          (sat_o),
        .unsat_o        (unsat_o)
    );

    assign busy_o = busy;

    // model is the value field of every record
    for (genvar k = 0; k < NUM_VARS; k++) begin : g_model
        assign assign_o[k] = var_states[k].value;
    end

endmodule

// File: test/tb_sat_engine.sv
// testbench for sat_engine with problem table, busy handling, random clause sets and brute-force model

`timescale 1ns/1ps

module tb_sat_engine;

    localparam int NV          = 8;
    localparam int NC          = 8;
    localparam int NUM_ENTRIES = 9;
    localparam int NUM_RANDOM  = 20;
    localparam int TIMEOUT     = 20000;

    // 2-bit literal field per variable with variable j at bits 2j+1:2j
    localparam logic [1:0] CODE_POS = 2'b01;
    localparam logic [1:0] CODE_NEG = 2'b10;

    typedef struct packed {
        logic [3:0]                count;
        logic [NC-1:0][2*NV-1:0]   cls;
        logic                      exp_sat;
    } problem_t;

    logic            clk;
    logic            rst_i;
    logic            wr_clause_i;
    logic [2:0]      wr_idx_i;
    logic [2*NV-1:0] wr_clause_data_i;
    logic            clr_clauses_i;
    logic            start_i;
    logic            busy_o;
    logic            done_o;
    logic            sat_o;
    logic            unsat_o;
    logic [NV-1:0]   assign_o;
    logic [3:0]      cur_lvl_o;

    string    tbl_name [NUM_ENTRIES];
    problem_t tbl      [NUM_ENTRIES];
    int       mismatches;
    int       table_errors;
    int       timeouts;
    integer   seed;

    sat_engine #(
        .NUM_VARS    (NV),
        .NUM_CLAUSES (NC)
    ) u_sat_engine (
        .clk              (clk),
        .rst_i            (rst_i),
        .wr_clause_i      (wr_clause_i),
        .wr_idx_i         (wr_idx_i),
        .wr_clause_data_i (wr_clause_data_i),
        .clr_clauses_i    (clr_clauses_i),
        .start_i          (start_i),
        .busy_o           (busy_o),
        .done_o           (done_o),
        .sat_o            (sat_o),
        .unsat_o          (unsat_o),
        .assign_o         (assign_o),
        .cur_lvl_o        (cur_lvl_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // signed 1-based variable numbers with 0 for an unused slot
    function automatic logic [2*NV-1:0] make_clause(int a, int b, int c);
        logic [2*NV-1:0] cl;
        int              lits [3];
        cl   = '0;
        lits = '{a, b, c};
        foreach (lits[n]) begin
            if (lits[n] > 0) begin
                cl[2*(lits[n]-1) +: 2] = CODE_POS;
            end else if (lits[n] < 0) begin
                cl[2*(-lits[n]-1) +: 2] = CODE_NEG;
            end
        end
        return cl;
    endfunction

    function automatic bit clause_holds(logic [2*NV-1:0] cl, logic [NV-1:0] a);
        bit hit;
        hit = 1'b0;
        for (int j = 0; j < NV; j++) begin
            if ((cl[2*j +: 2] == CODE_POS && a[j]) || (cl[2*j +: 2] == CODE_NEG && !a[j])) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic bit all_hold(problem_t p, logic [NV-1:0] a);
        for (int k = 0; k < p.count; k++) begin
            if (!clause_holds(p.cls[k], a)) return 1'b0;
        end
        return 1'b1;
    endfunction

    // every one of the 256 assignments
    function automatic bit brute_force_sat(problem_t p);
        for (int v = 0; v < (1 << NV); v++) begin
            if (all_hold(p, NV'(v))) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic build_table();
        foreach (tbl[e]) tbl[e] = '0;
        tbl_name[0] = "no_clauses";
        tbl[0].exp_sat = 1'b1;
        tbl_name[1] = "single_unit";
        tbl[1].count = 1;
        tbl[1].exp_sat = 1'b1;
        tbl[1].cls[0] = make_clause(1, 0, 0);
        tbl_name[2] = "unit_chain";
        tbl[2].count = 5;
        tbl[2].exp_sat = 1'b1;
        tbl[2].cls[0] = make_clause(1, 0, 0);
        for (int k = 1; k < 5; k++) begin
            tbl[2].cls[k] = make_clause(-k, k + 1, 0);
        end
        tbl_name[3] = "two_var_all";
        tbl[3].count = 4;
        tbl[3].cls[0] = make_clause(1, 2, 0);
        tbl[3].cls[1] = make_clause(1, -2, 0);
        tbl[3].cls[2] = make_clause(-1, 2, 0);
        tbl[3].cls[3] = make_clause(-1, -2, 0);
        // all eight sign patterns over three variables
        tbl_name[4] = "three_var_all";
        tbl[4].count = 8;
        for (int s = 0; s < 8; s++) begin
            tbl[4].cls[s] = make_clause(s[0] ? -1 : 1, s[1] ? -2 : 2, s[2] ? -3 : 3);
        end
        tbl_name[5] = "pigeon_2_1";
        tbl[5].count = 3;
        tbl[5].cls[0] = make_clause(1, 0, 0);
        tbl[5].cls[1] = make_clause(2, 0, 0);
        tbl[5].cls[2] = make_clause(-1, -2, 0);
        // first decision x1=0 must be flipped
        tbl_name[6] = "flip_first";
        tbl[6].count = 3;
        tbl[6].exp_sat = 1'b1;
        tbl[6].cls[0] = make_clause(1, 2, 0);
        tbl[6].cls[1] = make_clause(1, -2, 0);
        tbl[6].cls[2] = make_clause(-1, 3, 0);
        tbl_name[7] = "mixed_sat";
        tbl[7].count = 6;
        tbl[7].exp_sat = 1'b1;
        tbl[7].cls[0] = make_clause(8, 0, 0);
        tbl[7].cls[1] = make_clause(-8, 7, 0);
        tbl[7].cls[2] = make_clause(1, 2, 3);
        tbl[7].cls[3] = make_clause(-1, -2, 0);
        tbl[7].cls[4] = make_clause(-5, 6, -7);
        tbl[7].cls[5] = make_clause(-3, -6, 0);
        tbl_name[8] = "two_level_unsat";
        tbl[8].count = 4;
        tbl[8].cls[0] = make_clause(1, 2, 0);
        tbl[8].cls[1] = make_clause(1, -2, 0);
        tbl[8].cls[2] = make_clause(-1, 3, 0);
        tbl[8].cls[3] = make_clause(-1, -3, 0);
    endtask

    // eight 3-literal clauses over 3 to 8 variables
    task automatic make_random(output problem_t p);
        int nv;
        int v [3];
        int r0;
        p       = '0;
        p.count = NC;
        nv      = 3 + int'($unsigned($random(seed)) % 6);
        for (int k = 0; k < NC; k++) begin
            v[0] = int'($unsigned($random(seed)) % nv);
            v[1] = (v[0] + 1 + int'($unsigned($random(seed)) % (nv - 1))) % nv;
            r0   = int'($unsigned($random(seed)) % nv);
            v[2] = -1;
            for (int t = 0; t < nv; t++) begin
                if (v[2] < 0 && (r0 + t) % nv != v[0] && (r0 + t) % nv != v[1]) begin
                    v[2] = (r0 + t) % nv;
                end
            end
            foreach (v[n]) begin
                v[n] = ($random(seed) & 1) ? -(v[n] + 1) : v[n] + 1;
            end
            p.cls[k] = make_clause(v[0], v[1], v[2]);
        end
        p.exp_sat = brute_force_sat(p);
    endtask

    task automatic load_problem(problem_t p);
        @(posedge clk);
        clr_clauses_i <= 1'b1;
        @(posedge clk);
        clr_clauses_i <= 1'b0;
        for (int k = 0; k < p.count; k++) begin
            wr_clause_i      <= 1'b1;
            wr_idx_i         <= 3'(k);
            wr_clause_data_i <= p.cls[k];
            @(posedge clk);
        end
        wr_clause_i <= 1'b0;
    endtask

    task automatic pulse_start(string name);
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        // previous verdict is gone once the start is taken
        if (busy_o !== 1'b1 || done_o !== 1'b0 || sat_o !== 1'b0 || unsat_o !== 1'b0) begin
            $display("MISMATCH %s: expected busy/done/sat/unsat 1/0/0/0, actual %b/%b/%b/%b",
                     name, busy_o, done_o, sat_o, unsat_o);
            mismatches++;
        end
    endtask

    task automatic wait_done(string name, output bit finished);
        int cycles;
        finished = 1'b0;
        cycles   = 0;
        while (!finished && cycles < TIMEOUT) begin
            if (done_o === 1'b1) begin
                finished = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!finished) begin
            $display("%s: done_o did not rise within %0d cycles", name, TIMEOUT);
            timeouts++;
        end
    endtask

    // running search has opened its first decision level
    task automatic wait_decision(string name, output bit reached);
        int cycles;
        reached = 1'b0;
        cycles  = 0;
        while (!reached && cycles < TIMEOUT) begin
            if (cur_lvl_o !== 4'd0) begin
                reached = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!reached) begin
            $display("%s: no decision was made within %0d cycles", name, TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic check_result(string name, problem_t p);
        bit exp;
        exp = brute_force_sat(p);
        if (sat_o !== exp || unsat_o !== !exp || busy_o !== 1'b0) begin
            $display("MISMATCH %s: expected sat/unsat/busy %b/%b/0, actual %b/%b/%b",
                     name, exp, !exp, sat_o, unsat_o, busy_o);
            mismatches++;
        end
        if (sat_o === 1'b1 && !all_hold(p, assign_o)) begin
            $display("MISMATCH %s: expected a model satisfying every clause, actual assign_o %h",
                     name, assign_o);
            mismatches++;
        end
    endtask

    task automatic run_problem(string name, problem_t p);
        bit fin;
        load_problem(p);
        pulse_start(name);
        wait_done(name, fin);
        if (fin) check_result(name, p);
    endtask

    initial begin
        bit       fin;
        problem_t p;
        mismatches       = 0;
        table_errors     = 0;
        timeouts         = 0;
        seed             = 32'h69df_01e8;
        rst_i            = 1'b1;
        wr_clause_i      = 1'b0;
        wr_idx_i         = '0;
        wr_clause_data_i = '0;
        clr_clauses_i    = 1'b0;
        start_i          = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        if (busy_o !== 1'b0 || done_o !== 1'b0 || sat_o !== 1'b0 || unsat_o !== 1'b0 ||
            cur_lvl_o !== 4'd0) begin
            $display("MISMATCH after_reset: expected busy/done/sat/unsat/lvl 0/0/0/0/0, " ,
                     "actual %b/%b/%b/%b/%0d", busy_o, done_o, sat_o, unsat_o, cur_lvl_o);
            mismatches++;
        end

        // table entries back to back so each start has a previous verdict to clear
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (tbl[e].exp_sat != brute_force_sat(tbl[e])) begin
                $display("table entry %s has a result flag that the brute force contradicts",
                         tbl_name[e]);
                table_errors++;
            end
            run_problem(tbl_name[e], tbl[e]);
        end

        // start and clause write while busy where the write would make mixed_sat unsat
        p = tbl[7];
        load_problem(p);
        pulse_start("busy_ignore");
        wait_decision("busy_ignore", fin);
        @(posedge clk);
        start_i          <= 1'b1;
        wr_clause_i      <= 1'b1;
        wr_idx_i         <= 3'(p.count);
        wr_clause_data_i <= make_clause(-8, 0, 0);
        @(negedge clk);
        if (busy_o !== 1'b1) begin
            $display("MISMATCH busy_ignore: expected busy_o 1, actual %b", busy_o);
            mismatches++;
        end
        @(posedge clk);
        start_i     <= 1'b0;
        wr_clause_i <= 1'b0;
        @(negedge clk);
        // a taken start would have dropped the level back to 0
        if (cur_lvl_o === 4'd0) begin
            $display("MISMATCH busy_ignore: expected cur_lvl_o above 0, actual %0d", cur_lvl_o);
            mismatches++;
        end
        wait_done("busy_ignore", fin);
        if (fin) check_result("busy_ignore", p);
        pulse_start("busy_ignore_rerun");
        wait_done("busy_ignore_rerun", fin);
        if (fin) check_result("busy_ignore_rerun", p);

        for (int r = 0; r < NUM_RANDOM; r++) begin
            make_random(p);
            run_problem($sformatf("random_%0d", r), p);
        end

        $display("error counts: mismatch %0d, table %0d, timeout %0d",
                 mismatches, table_errors, timeouts);
        if (mismatches == 0 && table_errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tb.f
src/sat_types_pkg.sv
src/sat_ctrl_pkg.sv
src/sat_clause_regs.sv
src/clause_eval.sv
src/var_state_list.sv
src/sat_ctrl_core.sv
src/sat_engine.sv
test/tb_sat_engine.sv

// File: run_sim.sh
#!/bin/sh
# build the SAT engine testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sat_engine -f tb.f -o sim_tb_sat_engine
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_sat_engine > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi
exit 0
